// File: include/pufSession_params.svh
`ifndef PUF_SESSION_PARAMS_SVH
`define PUF_SESSION_PARAMS_SVH

////////////////////////////////////////////////////////////
// Host interface widths
////////////////////////////////////////////////////////////

`define PUF_REG_DATA_W      32  // Parameter register word
`define PUF_REG_ADDR_W      8   // Parameter register address
`define PUF_INMEM_ADDR_W    17  // Input memory byte address
`define PUF_OUTMEM_ADDR_W   13  // Output and result memory byte address
`define PUF_BYTE_W          8   // One memory byte

////////////////////////////////////////////////////////////
// Session counts and lengths
////////////////////////////////////////////////////////////

`define PUF_CONFIG_BYTES    16  // Delay-line configuration bytes
`define PUF_RAW_RESPONSE_W  6   // Raw response from the engine
`define PUF_CALIB_WORD_W    16  // Raw response after zero extension
`define PUF_CALIB_WAIT      10  // Cycles from trigger to capture

// Bytes copied from the result memory in the test modes
`define PUF_RESULT_LENGTH   64

// Operation mode codes held in parameter register 0
`define PUF_MODE_CALIBRATE   0
`define PUF_MODE_TEMPERATURE 1

`endif

// File: hdl/pufSessionPkg.sv
`default_nettype none

`include "pufSession_params.svh"

package pufSessionPkg;

	////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////

	typedef logic [`PUF_REG_DATA_W-1:0] regData_t;         // Parameter register word
	typedef logic [`PUF_REG_ADDR_W-1:0] regAddr_t;         // Parameter register address
	typedef logic [`PUF_INMEM_ADDR_W-1:0] inAddr_t;        // Input memory address
	typedef logic [`PUF_OUTMEM_ADDR_W-1:0] outAddr_t;      // Output and result memory address
	typedef logic [`PUF_BYTE_W-1:0] dataByte_t;            // Memory byte
	typedef logic [`PUF_RAW_RESPONSE_W-1:0] rawResponse_t; // Engine raw response

	// Full delay-line configuration, byte i in bits 8i+7:8i
	typedef logic [`PUF_CONFIG_BYTES*`PUF_BYTE_W-1:0] pdlConfig_t;

	////////////////////////////////////////////////////////////
	// Enumerations
	////////////////////////////////////////////////////////////

	// Decoded operation mode
	typedef enum logic [1:0] {
		modeCalibrate,   // Trigger, wait, capture raw response
		modeTemperature, // Test run with temperature read
		modeNormal       // Plain test run
	} pufMode_t;

	// Session sequencer
	typedef enum logic [2:0] {
		stIdle,      // Waiting for the run flag
		stFetch,     // Reading the parameter registers
		stLoad,      // Reading the configuration bytes
		stEvaluate,  // Engine run and result write-back
		stWriteBack  // Results written, clearing the run flag
	} sessionState_t;

endpackage

`default_nettype wire

// File: hdl/sessionConfig.sv
`timescale 1ns/1ps
`default_nettype none

`include "pufSession_params.svh"

module sessionConfig (
	input wire logic clk,
	input wire logic reset,
	input wire logic fetchStart,                          // Pulse, start reading registers
	input wire logic register32CmdAck,                    // Accepts the request with req
	input wire logic register32ReadDataValid,             // One cycle per returned word
	input wire pufSessionPkg::regData_t register32ReadData,
	output logic register32CmdReq,
	output pufSessionPkg::regAddr_t register32Address,
	output logic fetchDone,                               // Pulse after the second word
	output pufSessionPkg::pufMode_t mode,
	output pufSessionPkg::regData_t pcChallenge,          // Register 1
	output logic readTemp                                 // Temperature test requested
);

	// Register 1 is the last one read
	localparam pufSessionPkg::regAddr_t LastAddress = pufSessionPkg::regAddr_t'(1);

	pufSessionPkg::regData_t modeWord; // Register 0 once both words are in
	logic wordCount;                   // Set after the first word returns

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			register32CmdReq <= 1'b0;
			register32Address <= '0;
		end else if (fetchStart) begin
			register32CmdReq <= 1'b1;
			register32Address <= '0;
		end else if (register32CmdReq && register32CmdAck) begin
			register32Address <= register32Address + 1'b1; // Next register on accept
			if (register32Address == LastAddress) begin
				register32CmdReq <= 1'b0; // Both reads issued
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Return side, words shift through challenge into mode
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			wordCount <= 1'b0;
			fetchDone <= 1'b0;
			modeWord <= '0;
		end else begin
			fetchDone <= 1'b0;
			if (fetchStart) begin
				wordCount <= 1'b0;
			end else if (register32ReadDataValid) begin
				modeWord <= pcChallenge;  // Previous word moves down
				wordCount <= 1'b1;
				fetchDone <= wordCount;   // Second word closes the fetch
			end
		end
	end

	always_ff @(posedge clk) begin
		if (register32ReadDataValid) begin
			pcChallenge <= register32ReadData;
		end
	end

	// Mode decode, anything above the two codes runs a normal test
	always_comb begin
		if (modeWord == pufSessionPkg::regData_t'(`PUF_MODE_CALIBRATE)) begin
			mode = pufSessionPkg::modeCalibrate;
		end else if (modeWord == pufSessionPkg::regData_t'(`PUF_MODE_TEMPERATURE)) begin
			mode = pufSessionPkg::modeTemperature;
		end else begin
			mode = pufSessionPkg::modeNormal;
		end
	end

	assign readTemp = (mode == pufSessionPkg::modeTemperature); // Engine input

	// A pending request waits for its accept
	reqHeldUntilAccept: assert property (@(posedge clk) disable iff (reset)
		register32CmdReq && !register32CmdAck |=> register32CmdReq);

endmodule

`default_nettype wire

// File: hdl/challengeLoader.sv
`timescale 1ns/1ps
`default_nettype none

`include "pufSession_params.svh"

module challengeLoader (
	input wire logic clk,
	input wire logic reset,
	input wire logic loadStart,                           // Pulse, start the byte reads
	input wire logic inputMemoryReadAck,
	input wire logic inputMemoryReadDataValid,
	input wire pufSessionPkg::dataByte_t inputMemoryReadData,
	output logic inputMemoryReadReq,
	output pufSessionPkg::inAddr_t inputMemoryReadAdd,
	output logic loadDone,                                // Pulse after the last byte
	output pufSessionPkg::pdlConfig_t pdlConfig
);

	localparam int ByteIdxW = $clog2(`PUF_CONFIG_BYTES);
	localparam logic [ByteIdxW-1:0] LastByte = ByteIdxW'(`PUF_CONFIG_BYTES - 1);

	logic [ByteIdxW-1:0] byteIndex; // Byte currently in flight
	logic readPending;              // Accepted, data not yet back

	////////////////////////////////////////////////////////////
	// One read at a time
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			inputMemoryReadReq <= 1'b0;
			inputMemoryReadAdd <= '0;
			readPending <= 1'b0;
			byteIndex <= '0;
			loadDone <= 1'b0;
		end else begin
			loadDone <= 1'b0;
			if (loadStart) begin
				inputMemoryReadReq <= 1'b1;
				inputMemoryReadAdd <= '0;
				byteIndex <= '0;
			end else if (inputMemoryReadReq && inputMemoryReadAck) begin
				inputMemoryReadReq <= 1'b0; // Drop until the byte returns
				readPending <= 1'b1;
			end else if (readPending && inputMemoryReadDataValid) begin
				readPending <= 1'b0;
				if (byteIndex == LastByte) begin
					loadDone <= 1'b1;
				end else begin
					// Next address goes out with a fresh request
					byteIndex <= byteIndex + 1'b1;
					inputMemoryReadAdd <= inputMemoryReadAdd + 1'b1;
					inputMemoryReadReq <= 1'b1;
				end
			end
		end
	end

	// Byte i lands little-end first in the configuration
	always_ff @(posedge clk) begin
		if (readPending && inputMemoryReadDataValid) begin
			pdlConfig[byteIndex * `PUF_BYTE_W +: `PUF_BYTE_W] <= inputMemoryReadData;
		end
	end

	// Memory sees at most one outstanding read
	singleOutstanding: assert property (@(posedge clk) disable iff (reset)
		readPending |-> !inputMemoryReadReq);

endmodule

`default_nettype wire

// File: hdl/evaluationUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "pufSession_params.svh"

module evaluationUnit (
	input wire logic clk,
	input wire logic reset,
	input wire logic evalStart,                           // Pulse from the controller
	input wire pufSessionPkg::pufMode_t mode,
	input wire pufSessionPkg::rawResponse_t rawResponse,
	input wire logic testDone,                            // Engine finished a test run
	input wire pufSessionPkg::dataByte_t resultData,      // Valid one cycle after the address
	input wire logic outputMemoryWriteAck,
	output logic calibTrigger,                            // One-cycle pulse
	output logic testStart,                               // Level until testDone
	output pufSessionPkg::outAddr_t resultAddr,
	output logic outputMemoryWriteReq,
	output pufSessionPkg::outAddr_t outputMemoryWriteAdd,
	output pufSessionPkg::dataByte_t outputMemoryWriteData,
	output logic evalDone                                 // Pulse after the last write
);

	localparam int WaitW = $clog2(`PUF_CALIB_WAIT + 1);
	localparam logic [WaitW-1:0] CalibWait = WaitW'(`PUF_CALIB_WAIT);

	typedef enum logic [2:0] {
		evIdle,      // Waiting for evalStart
		evCalibWait, // Counting from trigger to capture
		evTestRun,   // testStart held, waiting for done
		evRead,      // Result address on the bus
		evCapture,   // Result byte valid
		evWrite      // Write request pending
	} evalState_t;

	evalState_t state;
	logic [WaitW-1:0] waitCount;                      // Cycles since the trigger
	logic [`PUF_CALIB_WORD_W-1:0] rawExtended;         // Zero-extended raw response
	pufSessionPkg::dataByte_t calibLowByte;            // Second calibration byte
	pufSessionPkg::outAddr_t lastAddr;                 // Address of the final write
	logic captureNow;
	logic writeAccept;

	assign rawExtended = `PUF_CALIB_WORD_W'(rawResponse);
	assign captureNow = (state == evCalibWait) && (waitCount == CalibWait);
	assign writeAccept = outputMemoryWriteReq && outputMemoryWriteAck;

	// Two bytes in calibration, the result block otherwise
	always_comb begin
		if (mode == pufSessionPkg::modeCalibrate) begin
			lastAddr = pufSessionPkg::outAddr_t'(1);
		end else begin
			lastAddr = pufSessionPkg::outAddr_t'(`PUF_RESULT_LENGTH - 1);
		end
	end

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= evIdle;
			calibTrigger <= 1'b0;
			testStart <= 1'b0;
			outputMemoryWriteReq <= 1'b0;
			outputMemoryWriteAdd <= '0;
			resultAddr <= '0;
			waitCount <= '0;
			evalDone <= 1'b0;
		end else begin
			calibTrigger <= 1'b0;
			evalDone <= 1'b0;
			case (state)
				evIdle: begin
					if (evalStart) begin
						waitCount <= '0;
						outputMemoryWriteAdd <= '0;
						resultAddr <= '0;
						if (mode == pufSessionPkg::modeCalibrate) begin
							calibTrigger <= 1'b1;
							state <= evCalibWait;
						end else begin
							testStart <= 1'b1;
							state <= evTestRun;
						end
					end
				end
				evCalibWait: begin
					waitCount <= waitCount + 1'b1;
					if (captureNow) begin
						outputMemoryWriteReq <= 1'b1; // High byte first
						state <= evWrite;
					end
				end
				evTestRun: begin
					if (testDone) begin
						testStart <= 1'b0;
						state <= evRead;
					end
				end
				evRead: state <= evCapture;
				evCapture: begin
					outputMemoryWriteReq <= 1'b1;
					state <= evWrite;
				end
				evWrite: begin
					if (writeAccept && outputMemoryWriteAdd == lastAddr) begin
						outputMemoryWriteReq <= 1'b0;
						evalDone <= 1'b1;
						state <= evIdle;
					end else if (writeAccept) begin
						outputMemoryWriteAdd <= outputMemoryWriteAdd + 1'b1;
						if (mode != pufSessionPkg::modeCalibrate) begin
							// Fetch the next result byte before writing again
							outputMemoryWriteReq <= 1'b0;
							resultAddr <= resultAddr + 1'b1;
							state <= evRead;
						end
					end
				end
				default: state <= evIdle;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Write data
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (captureNow) begin
			outputMemoryWriteData <= rawExtended[`PUF_CALIB_WORD_W-1:`PUF_BYTE_W];
			calibLowByte <= rawExtended[`PUF_BYTE_W-1:0];
		end else if (state == evCapture) begin
			outputMemoryWriteData <= resultData;
		end else if (writeAccept && mode == pufSessionPkg::modeCalibrate) begin
			outputMemoryWriteData <= calibLowByte;
		end
	end

	// The engine sees a single trigger per calibration
	triggerOneCycle: assert property (@(posedge clk) disable iff (reset)
		calibTrigger |=> !calibTrigger);

endmodule

`default_nettype wire

// File: hdl/sessionController.sv
`timescale 1ns/1ps
`default_nettype none

module sessionController (
	input wire logic clk,
	input wire logic reset,
	input wire logic userRunValue, // Host run flag
	input wire logic fetchDone,
	input wire logic loadDone,
	input wire logic evalDone,
	output logic userRunClear,     // One-cycle pulse ending the session
	output logic fetchStart,
	output logic loadStart,
	output logic evalStart
);

	pufSessionPkg::sessionState_t state;

	////////////////////////////////////////////////////////////
	// Session sequence
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= pufSessionPkg::stIdle;
			userRunClear <= 1'b0;
			fetchStart <= 1'b0;
			loadStart <= 1'b0;
			evalStart <= 1'b0;
		end else begin
			// Strobes last a single cycle
			fetchStart <= 1'b0;
			loadStart <= 1'b0;
			evalStart <= 1'b0;
			userRunClear <= 1'b0;
			case (state)
				pufSessionPkg::stIdle: begin
					if (userRunValue && !userRunClear) begin
						fetchStart <= 1'b1;
						state <= pufSessionPkg::stFetch;
					end
				end
				pufSessionPkg::stFetch: begin
					if (fetchDone) begin
						loadStart <= 1'b1; // Mode and challenge in place
						state <= pufSessionPkg::stLoad;
					end
				end
				pufSessionPkg::stLoad: begin
					if (loadDone) begin
						evalStart <= 1'b1; // Configuration complete
						state <= pufSessionPkg::stEvaluate;
					end
				end
				pufSessionPkg::stEvaluate: begin
					if (evalDone) begin
						userRunClear <= 1'b1;
						state <= pufSessionPkg::stWriteBack;
					end
				end
				pufSessionPkg::stWriteBack: state <= pufSessionPkg::stIdle; // Clear pulse out
				default: state <= pufSessionPkg::stIdle;
			endcase
		end
	end

	// Host run register is cleared by a single pulse
	runClearPulse: assert property (@(posedge clk) disable iff (reset)
		userRunClear |=> !userRunClear);

endmodule

`default_nettype wire

// File: hdl/pufSessionTop.sv
`timescale 1ns/1ps
`default_nettype none

module pufSessionTop (
	input wire logic clk,
	input wire logic reset,
	input wire logic userRunValue,
	output logic userRunClear,
	// Parameter register file
	output logic register32CmdReq,
	input wire logic register32CmdAck,
	output pufSessionPkg::regAddr_t register32Address,
	input wire logic register32ReadDataValid,
	input wire pufSessionPkg::regData_t register32ReadData,
	// Input memory
	output logic inputMemoryReadReq,
	input wire logic inputMemoryReadAck,
	output pufSessionPkg::inAddr_t inputMemoryReadAdd,
	input wire logic inputMemoryReadDataValid,
	input wire pufSessionPkg::dataByte_t inputMemoryReadData,
	// Output memory
	output logic outputMemoryWriteReq,
	input wire logic outputMemoryWriteAck,
	output pufSessionPkg::outAddr_t outputMemoryWriteAdd,
	output pufSessionPkg::dataByte_t outputMemoryWriteData,
	// PUF engine
	output pufSessionPkg::pdlConfig_t pdlConfig,
	output pufSessionPkg::regData_t pcChallenge,
	output logic readTemp,
	output logic calibTrigger,
	output logic testStart,
	input wire pufSessionPkg::rawResponse_t rawResponse,
	input wire logic testDone,
	// Result memory read port
	output pufSessionPkg::outAddr_t resultAddr,
	input wire pufSessionPkg::dataByte_t resultData
);

	// Controller strobes and their answers
	logic fetchStart, loadStart, evalStart;
	logic fetchDone, loadDone, evalDone;
	pufSessionPkg::pufMode_t mode; // From the config block to the evaluator

	sessionController controller0 (.clk, .reset, .userRunValue, .fetchDone, .loadDone,
		.evalDone, .userRunClear, .fetchStart, .loadStart, .evalStart);

	sessionConfig config0 (.clk, .reset, .fetchStart, .register32CmdAck,
		.register32ReadDataValid, .register32ReadData, .register32CmdReq,
		.register32Address, .fetchDone, .mode, .pcChallenge, .readTemp);

	challengeLoader loader0 (.clk, .reset, .loadStart, .inputMemoryReadAck,
		.inputMemoryReadDataValid, .inputMemoryReadData, .inputMemoryReadReq,
		.inputMemoryReadAdd, .loadDone, .pdlConfig);

	evaluationUnit eval0 (.clk, .reset, .evalStart, .mode, .rawResponse, .testDone,
		.resultData, .outputMemoryWriteAck, .calibTrigger, .testStart, .resultAddr,
		.outputMemoryWriteReq, .outputMemoryWriteAdd, .outputMemoryWriteData, .evalDone);

endmodule

`default_nettype wire

// File: testbench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	// Reset held over the first ten rising edges
	initial begin
		reset = 1'b1;
		repeat (10) @(posedge clk);
		#1 reset = 1'b0; // Released with the other inputs
	end

endmodule

`default_nettype wire

// File: testbench/pufSessionTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pufSession_params.svh"

module pufSessionTb;

	localparam int SessionTimeout = 4000; // Cycles allowed per session
	localparam int ResetTimeout = 100;

	logic clk, reset;
	logic userRunValue, userRunClear;
	logic register32CmdReq, register32CmdAck, register32ReadDataValid;
	pufSessionPkg::regAddr_t register32Address;
	pufSessionPkg::regData_t register32ReadData;
	logic inputMemoryReadReq, inputMemoryReadAck, inputMemoryReadDataValid;
	pufSessionPkg::inAddr_t inputMemoryReadAdd;
	pufSessionPkg::dataByte_t inputMemoryReadData;
	logic outputMemoryWriteReq, outputMemoryWriteAck;
	pufSessionPkg::outAddr_t outputMemoryWriteAdd, resultAddr;
	pufSessionPkg::dataByte_t outputMemoryWriteData, resultData;
	pufSessionPkg::pdlConfig_t pdlConfig;
	pufSessionPkg::regData_t pcChallenge;
	logic readTemp, calibTrigger, testStart, testDone;
	pufSessionPkg::rawResponse_t rawResponse;

	pufSessionPkg::regData_t regFile [2];                   // Mode word, challenge word
	pufSessionPkg::dataByte_t inMem [`PUF_CONFIG_BYTES];    // Configuration bytes
	pufSessionPkg::regAddr_t regQueue [$];                  // Accepted register reads
	pufSessionPkg::inAddr_t inQueue [$];
	pufSessionPkg::regAddr_t regAddrNow;
	pufSessionPkg::inAddr_t inAddrNow;
	pufSessionPkg::dataByte_t resultNext;
	int regAckWait = 0, regDataWait = 0, inAckWait = 0, inDataWait = 0;
	int outAckWait = 0, engineWait = 3;
	int errorCount = 0, testCount = 0, failedTests = 0;
	int writeCount = 0, clearCount = 0, triggerCount = 0, triggerAge = 0;
	logic startSeen, prevStart = 1'b0, prevWriteReq = 1'b0, doneSeen = 1'b0;
	bit timedOut = 1'b0;

	clockGen clockGen0 (.clk, .reset);

	pufSessionTop dut0 (.*);

	////////////////////////////////////////////////////////////
	// Reference rules and compare tasks
	////////////////////////////////////////////////////////////

	function automatic int randomDelay();
		return int'($urandom % 4); // 0 to 3 cycles
	endfunction

	// Result memory contents for the current challenge
	function automatic pufSessionPkg::dataByte_t resultByte(pufSessionPkg::outAddr_t k);
		return 8'(k * 7) + regFile[1][7:0];
	endfunction

	function automatic int expectedLength(pufSessionPkg::regData_t modeWord);
		return (modeWord == `PUF_MODE_CALIBRATE) ? 2 : `PUF_RESULT_LENGTH;
	endfunction

	// Expected byte at output address addr
	function automatic pufSessionPkg::dataByte_t expectedByte(pufSessionPkg::regData_t modeWord,
		pufSessionPkg::regData_t challenge, pufSessionPkg::rawResponse_t raw, int addr);
		logic [15:0] calibWord;
		calibWord = 16'(raw); // Zero-extended response with the high byte first
		if (modeWord == `PUF_MODE_CALIBRATE) begin
			return (addr == 0) ? calibWord[15:8] : calibWord[7:0];
		end
		return 8'(addr * 7) + challenge[7:0];
	endfunction

	task automatic reportProblem(string msg);
		errorCount++;
		$display("%s", msg);
	endtask

	task automatic checkByte(pufSessionPkg::outAddr_t addr, pufSessionPkg::dataByte_t got,
		pufSessionPkg::dataByte_t expected);
		if (got !== expected) begin
			errorCount++;
			$display("Fail at %0t ns: output byte %0d is %02h, expected %02h",
				$time, addr, got, expected);
		end
	endtask

	task automatic checkConfig(pufSessionPkg::pdlConfig_t got, pufSessionPkg::pdlConfig_t expected);
		if (got !== expected) begin
			errorCount++;
			$display("Fail at %0t ns: pdlConfig is %032h, expected %032h", $time, got, expected);
		end
	endtask

	task automatic checkWord(string what, pufSessionPkg::regData_t got,
		pufSessionPkg::regData_t expected);
		if (got !== expected) begin
			errorCount++;
			$display("Fail at %0t ns: %s is %08h, expected %08h", $time, what, got, expected);
		end
	endtask

	task automatic checkLevel(string what, logic got, logic expected);
		if (got !== expected) begin
			errorCount++;
			$display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, expected);
		end
	endtask

	////////////////////////////////////////////////////////////
	// Register file, memories and engine
	////////////////////////////////////////////////////////////

	initial begin : hardwareModels
		register32CmdAck = 1'b0;
		register32ReadDataValid = 1'b0;
		register32ReadData = '0;
		inputMemoryReadAck = 1'b0;
		inputMemoryReadDataValid = 1'b0;
		inputMemoryReadData = '0;
		outputMemoryWriteAck = 1'b0;
		testDone = 1'b0;
		resultData = '0;
		forever begin
			@(posedge clk);
			// Handshakes as the DUT saw them on this edge
			if (register32CmdReq && register32CmdAck) begin
				if (register32Address > pufSessionPkg::regAddr_t'(1)) begin
					reportProblem($sformatf("Read of unknown register %0d at %0t ns",
						register32Address, $time));
				end
				regQueue.push_back(register32Address);
				regAckWait = randomDelay();
				regDataWait = randomDelay();
			end
			if (inputMemoryReadReq && inputMemoryReadAck) begin
				if (int'(inputMemoryReadAdd) >= `PUF_CONFIG_BYTES) begin
					reportProblem($sformatf("Input memory read of address %0d at %0t ns",
						inputMemoryReadAdd, $time));
				end
				inQueue.push_back(inputMemoryReadAdd);
				inAckWait = randomDelay();
				inDataWait = randomDelay();
			end
			if (outputMemoryWriteReq && outputMemoryWriteAck) begin
				outAckWait = randomDelay();
			end
			startSeen = testStart;
			resultNext = resultByte(resultAddr); // Read port with one cycle of latency
			#1;
			register32CmdAck = (regAckWait == 0);
			inputMemoryReadAck = (inAckWait == 0);
			outputMemoryWriteAck = (outAckWait == 0);
			regAckWait = (regAckWait > 0) ? regAckWait - 1 : 0;
			inAckWait = (inAckWait > 0) ? inAckWait - 1 : 0;
			outAckWait = (outAckWait > 0) ? outAckWait - 1 : 0;
			register32ReadDataValid = 1'b0;
			if (regDataWait > 0) begin
				regDataWait--;
			end else if (regQueue.size() > 0) begin
				regAddrNow = regQueue.pop_front();
				register32ReadData = regFile[regAddrNow[0]];
				register32ReadDataValid = 1'b1;
			end
			inputMemoryReadDataValid = 1'b0;
			if (inDataWait > 0) begin
				inDataWait--;
			end else if (inQueue.size() > 0) begin
				inAddrNow = inQueue.pop_front();
				inputMemoryReadData = inMem[inAddrNow[3:0]];
				inputMemoryReadDataValid = 1'b1;
			end
			resultData = resultNext;
			// Engine answers a held testStart with a one-cycle done
			if (testDone) begin
				testDone = 1'b0;
				engineWait = 2 + randomDelay();
			end else if (startSeen && engineWait > 0) begin
				engineWait--;
			end else if (startSeen) begin
				testDone = 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Compare process
	////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		if (!reset) begin
			if (outputMemoryWriteReq && outputMemoryWriteAck) begin
				if (int'(outputMemoryWriteAdd) != writeCount
					|| writeCount >= expectedLength(regFile[0])) begin
					reportProblem($sformatf("Write to address %0d at %0t ns came after %0d writes",
						outputMemoryWriteAdd, $time, writeCount));
				end
				checkByte(outputMemoryWriteAdd, outputMemoryWriteData,
					expectedByte(regFile[0], regFile[1], rawResponse, writeCount));
				writeCount++;
			end
			if (userRunClear) begin
				clearCount++;
				if (writeCount != expectedLength(regFile[0])) begin
					reportProblem($sformatf("Run-clear at %0t ns after only %0d writes",
						$time, writeCount));
				end
			end
			triggerAge++;
			if (calibTrigger) begin
				triggerCount++;
				triggerAge = 0;
			end
			// First write request follows the capture edge
			if (outputMemoryWriteReq && !prevWriteReq && regFile[0] == `PUF_MODE_CALIBRATE
				&& triggerAge != `PUF_CALIB_WAIT + 1) begin
				reportProblem($sformatf("Calibration write-back began %0d cycles after the trigger",
					triggerAge));
			end
			if (prevStart && !testStart && !doneSeen) begin
				reportProblem($sformatf("testStart dropped at %0t ns before testDone", $time));
			end
			if (testDone) begin
				doneSeen = 1'b1;
			end else if (!testStart) begin
				doneSeen = 1'b0;
			end
			prevStart = testStart;
			prevWriteReq = outputMemoryWriteReq;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	task automatic finishTest(string name, int errorsBefore);
		testCount++;
		if (errorCount != errorsBefore) begin
			failedTests++;
		end
		$display("Test %s: %s", name, (errorCount == errorsBefore) ? "passed" : "failed");
	endtask

	// Outputs stay quiet while the run flag is low
	task automatic checkIdle(int cycles);
		int errorsBefore;
		errorsBefore = errorCount;
		repeat (cycles) begin
			@(posedge clk);
			#1;
			checkLevel("idle outputs", |{register32CmdReq, inputMemoryReadReq,
				outputMemoryWriteReq, calibTrigger, testStart, userRunClear}, 1'b0);
		end
		finishTest("idle after reset", errorsBefore);
	endtask

	task automatic runSession(string name, pufSessionPkg::regData_t modeWord,
		pufSessionPkg::regData_t challenge, pufSessionPkg::rawResponse_t raw);
		int errorsBefore;
		int cycles;
		int i;
		logic clearSeen;
		pufSessionPkg::pdlConfig_t expectedConfig;
		errorsBefore = errorCount;
		@(posedge clk);
		#1;
		regFile[0] = modeWord;
		regFile[1] = challenge;
		for (i = 0; i < `PUF_CONFIG_BYTES; i++) begin
			inMem[i] = pufSessionPkg::dataByte_t'($urandom);
			expectedConfig[8*i +: 8] = inMem[i]; // Byte i in bits 8i+7:8i
		end
		writeCount = 0;
		clearCount = 0;
		triggerCount = 0;
		rawResponse = raw;
		userRunValue = 1'b1;
		cycles = 0;
		clearSeen = 1'b0;
		while (!clearSeen && cycles < SessionTimeout) begin
			@(posedge clk);
			clearSeen = userRunClear;
			cycles++;
		end
		#1;
		userRunValue = 1'b0; // Host clears its run register
		if (!clearSeen) begin
			timedOut = 1'b1;
			reportProblem($sformatf("Session %s got no run-clear within %0d cycles",
				name, SessionTimeout));
		end else begin
			repeat (3) @(posedge clk);
			#1;
			checkConfig(pdlConfig, expectedConfig);
			checkWord("pcChallenge", pcChallenge, challenge);
			checkLevel("readTemp", readTemp, modeWord == `PUF_MODE_TEMPERATURE);
			if (clearCount != 1) begin
				reportProblem($sformatf("Session %s saw %0d run-clear pulses", name, clearCount));
			end
			if (writeCount != expectedLength(modeWord)) begin
				reportProblem($sformatf("Session %s wrote %0d bytes", name, writeCount));
			end
			if (triggerCount != ((modeWord == `PUF_MODE_CALIBRATE) ? 1 : 0)) begin
				reportProblem($sformatf("Session %s saw %0d calibration triggers",
					name, triggerCount));
			end
		end
		finishTest(name, errorsBefore);
	endtask

	initial begin : stimulus
		int cycles;
		int n;
		void'($urandom(24836));
		userRunValue = 1'b0;
		rawResponse = '0;
		cycles = 0;
		while (reset !== 1'b0 && cycles < ResetTimeout) begin
			@(posedge clk);
			cycles++;
		end
		if (reset !== 1'b0) begin
			timedOut = 1'b1;
			reportProblem("Reset was never released");
		end
		if (!timedOut) checkIdle(8);
		if (!timedOut) runSession("calibration", 32'd0, 32'h1234_5678, 6'h2d);
		if (!timedOut) runSession("normal", 32'd7, 32'hcafe_0142, 6'h11);
		if (!timedOut) runSession("temperature", 32'd1, 32'h0bad_f00d, 6'h3f);
		for (n = 0; n < 4; n++) begin
			if (!timedOut) begin
				runSession($sformatf("random %0d", n), pufSessionPkg::regData_t'($urandom % 4),
					pufSessionPkg::regData_t'($urandom), pufSessionPkg::rawResponse_t'($urandom));
			end
		end
		$display("Tests run %0d, failed %0d, errors %0d", testCount, failedTests, errorCount);
		if (errorCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
hdl/pufSessionPkg.sv
hdl/sessionConfig.sv
hdl/challengeLoader.sv
hdl/evaluationUnit.sv
hdl/sessionController.sv
hdl/pufSessionTop.sv
testbench/clockGen.sv
testbench/pufSessionTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the PUF session testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module pufSessionTb -Mdir obj_dir; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VpufSessionTb)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "RESULT: PASS"; then
	exit 0
fi
echo "Pass message not found"
exit 1
